//--- sources.f
+incdir+src
+incdir+bench
src/alu_lane_pkg.sv
src/phys_reg_file.sv
src/operand_station.sv
src/alu_exec.sv
src/alu_lane_top.sv
bench/alu_lane_tb.sv

//--- Makefile
# Verilator build and run of the ALU lane testbench

VERILATOR ?= verilator
TOP ?= alu_lane_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard src/*.svh bench/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/alu_lane_tests.svh
// Directed test tasks and their drivers, included into the body of the ALU lane testbench

// ======================================================================
// Drivers
// ======================================================================

function automatic issue_op_t make_op(input alu_op_e opc, input logic [4:0] ps1,
		input logic [4:0] ps2, input logic [4:0] pd, input logic [31:0] imm,
		input logic use_imm, input logic [3:0] tag);
	issue_op_t op;
	op.opcode = opc;
	op.ps1 = ps1;
	op.ps2 = ps2;
	op.pd = pd;
	op.imm = imm;
	op.use_imm = use_imm;
	op.rob_tag = tag;
	return op;
endfunction

// Destination in 1..8 that is not a source of the op and not the op possibly still in the ALU
function automatic logic [4:0] pick_dest(input logic [4:0] start, input issue_op_t op,
		input logic [4:0] prev);
	logic [4:0] pd;
	int k;
	pd = start;
	for (k = 0; k < 8; k++) begin
		if (pd == op.ps1 || (!op.use_imm && pd == op.ps2) || pd == prev) begin
			pd = (pd == 5'd8) ? 5'd1 : pd + 5'd1;
		end
	end
	return pd;
endfunction

// The task is entered and left 1 ns after a rising edge and holds the payload until the station takes it
task automatic send_op(input issue_op_t op);
	logic [`ALU_XLEN-1:0] a;
	logic [`ALU_XLEN-1:0] b;
	result_t want;
	logic accepted;
	int n;
	a = model[op.ps1];
	b = op.use_imm ? op.imm : model[op.ps2];
	want.rob_tag = op.rob_tag;
	want.pd = op.pd;
	want.value = expected_result(op.opcode, a, b);
	issue_op = op;
	issue_valid = 1'b1;
	accepted = 1'b0;
	n = 0;
	while (!accepted && n < WAIT_LIMIT) begin
		@(negedge clk);
		accepted = issue_ready;
		@(posedge clk);
		#1;
		n++;
	end
	issue_valid = 1'b0;
	if (accepted) begin
		exp_q.push_back(want);
		// Register 0 stays zero whatever is written to it
		if (op.pd != '0) begin
			model[op.pd] = want.value;
		end
		last_pd = op.pd;
	end else begin
		timeouts++;
		$display("ERROR %s: the issue port was not ready within %0d cycles", cur_test, WAIT_LIMIT);
	end
endtask

task automatic preload(input logic [4:0] preg, input logic [31:0] value);
	pre_wr.preg = preg;
	pre_wr.value = value;
	pre_valid = 1'b1;
	@(posedge clk);
	#1;
	pre_valid = 1'b0;
	if (preg != '0) begin
		model[preg] = value;
	end
endtask

task automatic wait_drain();
	int n;
	n = 0;
	while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
		@(posedge clk);
		#1;
		n++;
	end
	if (exp_q.size() != 0) begin
		timeouts++;
		$display("ERROR %s: %0d results never came out", cur_test, exp_q.size());
		exp_q.delete();
	end
endtask

// ======================================================================
// Tests
// ======================================================================

task automatic test_reset();
	cur_test = "test_reset";
	repeat (15) @(posedge clk);
	@(negedge clk);
	check_value("issue_ready in reset", 32'd0, 32'(issue_ready));
	@(posedge clk);
	#1;
	rst = 1'b0;
	// One edge out of reset the station shows it is idle
	@(posedge clk);
	#1;
	@(negedge clk);
	check_value("issue_ready", 32'd1, 32'(issue_ready));
	check_value("result_valid", 32'd0, 32'(result_valid));
	@(posedge clk);
	#1;
endtask

task automatic test_each_opcode();
	int k;
	cur_test = "test_each_opcode";
	preload(5'd1, rand_word());
	preload(5'd2, rand_word());
	for (k = 0; k < 8; k++) begin
		send_op(make_op(alu_op_e'(3'(k)), 5'd1, 5'd2, 5'(3 + k), '0, 1'b0, 4'(k)));
	end
	wait_drain();
endtask

task automatic test_immediate_and_zero();
	cur_test = "test_immediate_and_zero";
	preload(5'd1, rand_word());
	// This write to register 0 must be dropped
	preload(5'd0, rand_word());
	send_op(make_op(ADD, 5'd0, 5'd7, 5'd12, rand_word(), 1'b1, 4'd0));
	send_op(make_op(SUB, 5'd1, 5'd7, 5'd13, rand_word(), 1'b1, 4'd1));
	send_op(make_op(SLT, 5'd0, 5'd7, 5'd14, 32'hffff_fff0, 1'b1, 4'd2));
	send_op(make_op(OR, 5'd0, 5'd0, 5'd15, '0, 1'b0, 4'd3));
	send_op(make_op(ADD, 5'd1, 5'd1, 5'd0, '0, 1'b0, 4'd4));
	send_op(make_op(XOR, 5'd0, 5'd1, 5'd16, '0, 1'b0, 4'd5));
	// Shift amount 35 acts as 3
	send_op(make_op(SRL, 5'd1, 5'd7, 5'd17, 32'd35, 1'b1, 4'd6));
	wait_drain();
endtask

task automatic test_dependency();
	cur_test = "test_dependency";
	preload(5'd1, rand_word());
	preload(5'd2, rand_word());
	preload(5'd3, rand_word());
	// Each op reads what the one before it writes
	// The first result is held in the ALU, so the second op waits in the station for writeback
	ready_mode = 1;
	send_op(make_op(ADD, 5'd1, 5'd2, 5'd10, '0, 1'b0, 4'd1));
	send_op(make_op(SUB, 5'd10, 5'd3, 5'd11, '0, 1'b0, 4'd2));
	repeat (4) @(posedge clk);
	#1;
	ready_mode = 0;
	send_op(make_op(XOR, 5'd11, 5'd10, 5'd12, '0, 1'b0, 4'd3));
	wait_drain();
endtask

task automatic test_backpressure();
	int seen;
	int i;
	cur_test = "test_backpressure";
	preload(5'd1, rand_word());
	preload(5'd2, rand_word());
	ready_mode = 1;
	seen = results_seen;
	send_op(make_op(ADD, 5'd1, 5'd2, 5'd20, '0, 1'b0, 4'd7));
	send_op(make_op(SUB, 5'd2, 5'd1, 5'd21, '0, 1'b0, 4'd8));
	// One op sits in the ALU and one in the station, so nothing more may enter
	for (i = 0; i < 8; i++) begin
		@(negedge clk);
		check_value("issue_ready held low", 32'd0, 32'(issue_ready));
		check_value("result_valid held", 32'd1, 32'(result_valid));
		@(posedge clk);
		#1;
	end
	// The stalled result is still the oldest op
	check_value("held value", exp_q[0].value, result.value);
	check_value("held rob_tag", 32'(exp_q[0].rob_tag), 32'(result.rob_tag));
	fork
		send_op(make_op(OR, 5'd20, 5'd21, 5'd22, '0, 1'b0, 4'd9));
		begin
			repeat (4) @(posedge clk);
			#1;
			ready_mode = 0;
		end
	join
	wait_drain();
	check_value("results after release", 32'(seen + 3), 32'(results_seen));
endtask

task automatic test_random_stream();
	issue_op_t op;
	logic [31:0] r;
	int seen;
	int i;
	cur_test = "test_random_stream";
	for (i = 1; i <= 8; i++) begin
		preload(5'(i), rand_word());
	end
	ready_mode = 2;
	seen = results_seen;
	for (i = 0; i < 40; i++) begin
		r = rand_word();
		op.opcode = alu_op_e'(r[2:0]);
		op.ps1 = 5'(r[7:4] % 9);
		op.ps2 = 5'(r[11:8] % 9);
		op.use_imm = (r[13:12] == 2'b00);
		op.imm = rand_word();
		op.rob_tag = 4'(i);
		op.pd = pick_dest(5'(1 + r[19:16] % 8), op, last_pd);
		send_op(op);
	end
	wait_drain();
	ready_mode = 0;
	check_value("random result count", 32'(seen + 40), 32'(results_seen));
endtask

//--- bench/alu_lane_tb.sv
// Testbench top for the ALU lane, holding the clock, reset, DUT, reference model and drivers
`timescale 1ns/10ps
`default_nettype none

`include "alu_defs.svh"

module alu_lane_tb;
	import alu_lane_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam logic [31:0] SEED = 32'hc6f9_b26d;

	logic clk;
	logic rst;
	logic issue_valid;
	logic issue_ready;
	issue_op_t issue_op;
	logic result_valid;
	logic result_ready;
	result_t result;
	logic pre_valid;
	wr_port_t pre_wr;

	// Value each register holds once every accepted op has written back, in program order
	logic [`ALU_XLEN-1:0] model [`ALU_NPREG];

	// Results still owed by the DUT, oldest first
	result_t exp_q [$];

	string cur_test;
	int errors;
	int timeouts;
	int results_seen;

	// 0 keeps result_ready high, 1 holds it low, anything else draws it at random
	int ready_mode;

	logic [31:0] rng;
	logic [31:0] rdy_state;
	logic [`ALU_PREG_W-1:0] last_pd;

	alu_lane_top i_dut (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_op(issue_op),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result(result),
		.pre_valid(pre_valid),
		.pre_wr(pre_wr)
	);

	always #50 clk = ~clk;

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Opcode rules of the lane, shifts take only the low five bits of b
	function automatic logic [`ALU_XLEN-1:0] expected_result(input alu_op_e opc,
			input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
		case (opc)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what,
				expected, actual);
		end
	endtask

	// Sampled at the falling edge, so a high valid and ready here means a transfer at the next rise
	always @(negedge clk) begin : result_monitor
		result_t want;
		if (!rst && result_valid && result_ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR %s: a result came out with no operation outstanding", cur_test);
			end else begin
				want = exp_q.pop_front();
				check_value("value", want.value, result.value);
				check_value("pd", 32'(want.pd), 32'(result.pd));
				check_value("rob_tag", 32'(want.rob_tag), 32'(result.rob_tag));
			end
			results_seen++;
		end
	end

	// The mode is read on the edge itself so that a test changing it 1 ns later never races
	always @(posedge clk) begin : ready_drive
		int mode;
		mode = ready_mode;
		#1;
		case (mode)
			0: result_ready = 1'b1;
			1: result_ready = 1'b0;
			default: begin
				rdy_state = xorshift(rdy_state);
				result_ready = rdy_state[7];
			end
		endcase
	end

	`include "alu_lane_tests.svh"

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_op = '0;
		result_ready = 1'b1;
		pre_valid = 1'b0;
		pre_wr = '0;
		ready_mode = 0;
		rng = SEED;
		rdy_state = xorshift(SEED);
		errors = 0;
		timeouts = 0;
		results_seen = 0;
		last_pd = '0;
		cur_test = "startup";
		for (i = 0; i < `ALU_NPREG; i++) begin
			model[i] = '0;
		end

		test_reset();
		test_each_opcode();
		test_immediate_and_zero();
		test_dependency();
		test_backpressure();
		test_random_stream();

		$display("Summary: %0d check errors, %0d timeouts, %0d results seen",
			errors, timeouts, results_seen);
		if (errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/alu_lane_top.sv
// Top level of the ALU lane, connecting the station, register file and ALU
`timescale 1ns/10ps
`default_nettype none

`include "alu_defs.svh"

module alu_lane_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	output logic issue_ready,
	input alu_lane_pkg::issue_op_t issue_op,
	output logic result_valid,
	input wire logic result_ready,
	output alu_lane_pkg::result_t result,
	input wire logic pre_valid,
	input alu_lane_pkg::wr_port_t pre_wr
);
	import alu_lane_pkg::*;

	// ======================================================================
	// Internal connections
	// ======================================================================

	logic alloc_valid;
	logic [`ALU_PREG_W-1:0] alloc_preg;
	logic [`ALU_NPORTS-1:0][`ALU_PREG_W-1:0] rd_req;
	rd_port_t [`ALU_NPORTS-1:0] rd_resp;

	logic exec_valid;
	logic exec_ready;
	exec_op_t exec_op;

	// Writeback from the ALU into the register file
	logic wb_valid;
	wr_port_t wb;

	phys_reg_file i_prf (
		.clk(clk),
		.rst(rst),
		.alloc_valid(alloc_valid),
		.alloc_preg(alloc_preg),
		.wb_valid(wb_valid),
		.wb(wb),
		.pre_valid(pre_valid),
		.pre_wr(pre_wr),
		.rd_req(rd_req),
		.rd_resp(rd_resp)
	);

	operand_station i_station (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_ready(issue_ready),
		.alloc_valid(alloc_valid),
		.alloc_preg(alloc_preg),
		.rd_req(rd_req),
		.rd_resp(rd_resp),
		.exec_valid(exec_valid),
		.exec_ready(exec_ready),
		.exec_op(exec_op)
	);

	alu_exec i_alu (
		.clk(clk),
		.rst(rst),
		.exec_valid(exec_valid),
		.exec_op(exec_op),
		.exec_ready(exec_ready),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result(result),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

`default_nettype wire

//--- src/alu_exec.sv
// Single-cycle ALU with a result register and the result and writeback handshake
`timescale 1ns/10ps
`default_nettype none

`include "alu_defs.svh"

module alu_exec (
	input wire logic clk,
	input wire logic rst,
	input wire logic exec_valid,
	input alu_lane_pkg::exec_op_t exec_op,
	output logic exec_ready,
	output logic result_valid,
	input wire logic result_ready,
	output alu_lane_pkg::result_t result,
	output logic wb_valid,
	output alu_lane_pkg::wr_port_t wb
);
	import alu_lane_pkg::*;

	logic [`ALU_XLEN-1:0] value;

	// Only the low five bits of b count for a shift
	always_comb begin
		case (exec_op.opcode)
			ADD: value = exec_op.a + exec_op.b;
			SUB: value = exec_op.a - exec_op.b;
			AND: value = exec_op.a & exec_op.b;
			OR: value = exec_op.a | exec_op.b;
			XOR: value = exec_op.a ^ exec_op.b;
			SLL: value = exec_op.a << exec_op.b[4:0];
			SRL: value = exec_op.a >> exec_op.b[4:0];
			SLT: value = {{(`ALU_XLEN-1){1'b0}}, $signed(exec_op.a) < $signed(exec_op.b)};
			default: value = '0;
		endcase
	end

	// ======================================================================
	// Result register
	// ======================================================================

	// Take a new op when the register is empty or drains this cycle
	assign exec_ready = !result_valid || result_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else if (exec_valid && exec_ready) begin
			result_valid <= 1'b1;
		end else if (result_ready) begin
			result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exec_valid && exec_ready) begin
			result.rob_tag <= exec_op.rob_tag;
			result.pd <= exec_op.pd;
			result.value <= value;
		end
	end

	// The register file is written only when the result actually leaves
	assign wb_valid = result_valid && result_ready;
	assign wb.preg = result.pd;
	assign wb.value = result.value;

	a_result_stable: assert property (@(posedge clk) disable iff (rst)
		result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

`default_nettype wire

//--- src/operand_station.sv
// Single-entry reservation station that gathers operands and hands the op to the ALU
`timescale 1ns/10ps
`default_nettype none

`include "alu_defs.svh"

module operand_station (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input alu_lane_pkg::issue_op_t issue_op,
	output logic issue_ready,
	output logic alloc_valid,
	output logic [`ALU_PREG_W-1:0] alloc_preg,
	output logic [`ALU_NPORTS-1:0][`ALU_PREG_W-1:0] rd_req,
	input alu_lane_pkg::rd_port_t [`ALU_NPORTS-1:0] rd_resp,
	output logic exec_valid,
	input wire logic exec_ready,
	output alu_lane_pkg::exec_op_t exec_op
);
	import alu_lane_pkg::*;

	station_state_e state;
	station_state_e state_next;

	// Held operation and its operand values
	issue_op_t op;
	logic [`ALU_XLEN-1:0] a_val;
	logic [`ALU_XLEN-1:0] b_val;

	// Bit 0 tracks ps1 and bit 1 tracks ps2
	logic [1:0] src_ok;

	// High in the first GATHER cycle, while the responses still belong to older requests
	logic first;

	logic accept;
	logic [1:0] cap_ok;
	logic [`ALU_XLEN-1:0] cap_a;
	logic [`ALU_XLEN-1:0] cap_b;

	assign accept = issue_valid && issue_ready;

	// The destination is claimed in the same cycle the op is accepted
	assign alloc_valid = accept;
	assign alloc_preg = issue_op.pd;

	// Port 0 asks for ps1, port 1 for ps2
	assign rd_req[0] = op.ps1;
	assign rd_req[1] = op.ps2;

	// ======================================================================
	// Operand capture
	// ======================================================================

	// Any port may carry either source, as long as the answer is valid
	always_comb begin
		cap_ok = src_ok;
		cap_a = a_val;
		cap_b = b_val;
		if (state == GATHER && !first) begin
			for (int p = 0; p < `ALU_NPORTS; p++) begin
				if (rd_resp[p].valid && !src_ok[0] && rd_resp[p].preg == op.ps1) begin
					cap_a = rd_resp[p].value;
					cap_ok[0] = 1'b1;
				end
				if (rd_resp[p].valid && !src_ok[1] && rd_resp[p].preg == op.ps2) begin
					cap_b = rd_resp[p].value;
					cap_ok[1] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (accept) state_next = GATHER;
			// Fire as soon as the last missing source lands
			GATHER: if (!first && &cap_ok) state_next = FIRE;
			FIRE: if (exec_ready) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	// ======================================================================
	// State and payload registers
	// ======================================================================

	// issue_ready is kept as a flop so that it stays low through reset
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			issue_ready <= 1'b0;
			src_ok <= '0;
			first <= 1'b0;
		end else begin
			state <= state_next;
			issue_ready <= (state_next == IDLE);
			first <= accept;
			if (accept) begin
				// Register 0 and an immediate need nothing from the register file
				src_ok[0] <= (issue_op.ps1 == '0);
				src_ok[1] <= issue_op.use_imm || (issue_op.ps2 == '0);
			end else begin
				src_ok <= cap_ok;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op <= issue_op;
			a_val <= '0;
			b_val <= issue_op.use_imm ? issue_op.imm : '0;
		end else begin
			a_val <= cap_a;
			b_val <= cap_b;
		end
	end

	assign exec_valid = (state == FIRE);

	always_comb begin
		exec_op.opcode = op.opcode;
		exec_op.a = a_val;
		exec_op.b = b_val;
		exec_op.pd = op.pd;
		exec_op.rob_tag = op.rob_tag;
	end

	a_exec_stable: assert property (@(posedge clk) disable iff (rst)
		exec_valid && !exec_ready |=> exec_valid && $stable(exec_op));

	a_issue_only_idle: assert property (@(posedge clk) disable iff (rst)
		accept |-> state == IDLE);

endmodule

`default_nettype wire

//--- src/phys_reg_file.sv
// Physical register file with a ready scoreboard, instantiated once by the lane top level
`timescale 1ns/10ps
`default_nettype none

`include "alu_defs.svh"

module phys_reg_file (
	input wire logic clk,
	input wire logic rst,
	input wire logic alloc_valid,
	input wire logic [`ALU_PREG_W-1:0] alloc_preg,
	input wire logic wb_valid,
	input alu_lane_pkg::wr_port_t wb,
	input wire logic pre_valid,
	input alu_lane_pkg::wr_port_t pre_wr,
	input wire logic [`ALU_NPORTS-1:0][`ALU_PREG_W-1:0] rd_req,
	output alu_lane_pkg::rd_port_t [`ALU_NPORTS-1:0] rd_resp
);
	import alu_lane_pkg::*;

	// Register values, entry 0 is never written so it stays zero
	logic [`ALU_XLEN-1:0] regs [`ALU_NPREG];

	// One bit per register, set once its value has been written
	logic [`ALU_NPREG-1:0] ready;

	// ======================================================================
	// Write side and scoreboard
	// ======================================================================

	// The later assignment wins, so writeback overrides a preload to the same register
	// and an allocation clears the bit after any set in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ALU_NPREG; i++) begin
				regs[i] <= '0;
			end
			ready <= '1;
		end else begin
			if (pre_valid && pre_wr.preg != '0) begin
				regs[pre_wr.preg] <= pre_wr.value;
				ready[pre_wr.preg] <= 1'b1;
			end
			if (wb_valid && wb.preg != '0) begin
				regs[wb.preg] <= wb.value;
				ready[wb.preg] <= 1'b1;
			end
			// Register 0 is a constant and is never pending
			if (alloc_valid && alloc_preg != '0) begin
				ready[alloc_preg] <= 1'b0;
			end
		end
	end

	// ======================================================================
	// Read ports
	// ======================================================================

	// Every port answers each cycle with what it was asked for one cycle earlier.
	// The answer echoes the register number so the station can match it
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_resp <= '0;
		end else begin
			for (int p = 0; p < `ALU_NPORTS; p++) begin
				rd_resp[p].preg <= rd_req[p];
				rd_resp[p].valid <= ready[rd_req[p]];
				rd_resp[p].value <= regs[rd_req[p]];
			end
		end
	end

	// Renaming hands out a fresh destination, so an op still in the ALU cannot be
	// writing the register that a newly issued op claims
	a_alloc_wb_distinct: assert property (@(posedge clk) disable iff (rst)
		alloc_valid && wb_valid && alloc_preg != '0 |-> alloc_preg != wb.preg);

endmodule

`default_nettype wire

//--- src/alu_lane_pkg.sv
// Enums and packed structs shared by the ALU lane RTL and its testbench
`default_nettype none

`include "alu_defs.svh"

package alu_lane_pkg;

	// ======================================================================
	// Encodings
	// ======================================================================

	// SLT is a signed compare giving 1 or 0
	typedef enum logic [2:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
	} alu_op_e;

	typedef enum logic [1:0] {
		IDLE, GATHER, FIRE
	} station_state_e;

	// ======================================================================
	// Bundles
	// ======================================================================

	// Renamed operation as it arrives on the issue port
	typedef struct packed {
		alu_op_e opcode;
		logic [`ALU_PREG_W-1:0] ps1;
		logic [`ALU_PREG_W-1:0] ps2;
		logic [`ALU_PREG_W-1:0] pd;
		logic [`ALU_XLEN-1:0] imm;
		logic use_imm;
		logic [`ALU_ROB_W-1:0] rob_tag;
	} issue_op_t;

	// Operation with its operands resolved, b already holds the immediate if one was used
	typedef struct packed {
		alu_op_e opcode;
		logic [`ALU_XLEN-1:0] a;
		logic [`ALU_XLEN-1:0] b;
		logic [`ALU_PREG_W-1:0] pd;
		logic [`ALU_ROB_W-1:0] rob_tag;
	} exec_op_t;

	// One registered read port answer
	typedef struct packed {
		logic [`ALU_PREG_W-1:0] preg;
		logic valid;
		logic [`ALU_XLEN-1:0] value;
	} rd_port_t;

	typedef struct packed {
		logic [`ALU_PREG_W-1:0] preg;
		logic [`ALU_XLEN-1:0] value;
	} wr_port_t;

	typedef struct packed {
		logic [`ALU_ROB_W-1:0] rob_tag;
		logic [`ALU_PREG_W-1:0] pd;
		logic [`ALU_XLEN-1:0] value;
	} result_t;

endpackage

`default_nettype wire

//--- src/alu_defs.svh
// Shared width and size macros for the ALU lane, included by the package and every RTL module
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// ======================================================================
// Datapath sizes
// ======================================================================

// One machine word
`define ALU_XLEN 32

// Physical register file size, and the width of a register number
`define ALU_NPREG 32
`define ALU_PREG_W 5

// Read ports between the register file and the operand station
`define ALU_NPORTS 2

// Reorder-buffer tag width, carried through untouched
`define ALU_ROB_W 4

`endif
